/* Makefile */
TOP = tb_rob_except

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -o sim_$(TOP)
	-./obj_dir/sim_$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "Simulation PASSED" sim.log && ! grep -q "Simulation FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* dv/tb_rob_except.sv */
`timescale 1ns/1ns

module tb_rob_except;

  typedef logic [rob_pkg::BUNDLE_W-1:0] bundle_idx_t;
  typedef logic [rob_pkg::SLOT_W-1:0] slot_idx_t;

  logic clk;
  logic rst_n;
  logic dispatch;
  rob_pkg::except_entry_t [rob_pkg::SLOTS-1:0] dispatch_entries;
  rob_pkg::wr_req_t [rob_pkg::NUM_WR-1:0] wr;
  bundle_idx_t alloc_bundle;
  logic full;
  logic [6:0] count;
  logic retire;
  bundle_idx_t retire_bundle;
  logic flush;
  bundle_idx_t flush_bundle;
  slot_idx_t flush_slot;
  logic [3:0] flush_code;

  logic [15:0] lfsr;
  rob_pkg::except_entry_t model_mem [rob_pkg::BUNDLES][rob_pkg::SLOTS];
  int order[$]; // Bundle indices in flight, head first.
  int model_tail;
  int stall;
  int retire_cnt;
  int flush_cnt;
  bit saw_full;
  bit excp_en;

  rob_except_top uut (
    .clk             (clk),
    .rst_n           (rst_n),
    .dispatch        (dispatch),
    .dispatch_entries(dispatch_entries),
    .wr              (wr),
    .alloc_bundle    (alloc_bundle),
    .full            (full),
    .count           (count),
    .retire          (retire),
    .retire_bundle   (retire_bundle),
    .flush           (flush),
    .flush_bundle    (flush_bundle),
    .flush_slot      (flush_slot),
    .flush_code      (flush_code)
  );

  always #10 clk = ~clk;

  // Each bit taken costs one LFSR step.
  function automatic int rand_bits(input int n);
    int val;
    val = 0;
    for (int i = 0; i < n; i++) begin
      val = (val << 1) | int'(lfsr[0]);
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return val;
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_bundle(input string name, input bundle_idx_t got, input bundle_idx_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("mismatch at %0t ns: %s is %0d, expected %0d",
                                $time, name, got, exp));
    end
  endtask

  task automatic check_flush(input bundle_idx_t got_b, input bundle_idx_t exp_b,
                             input slot_idx_t got_s, input slot_idx_t exp_s,
                             input logic [3:0] got_c, input logic [3:0] exp_c);
    check_bundle("flush_bundle", got_b, exp_b);
    if (got_s !== exp_s) begin
      stop_with_error($sformatf("mismatch at %0t ns: flush_slot is %0d, expected %0d",
                                $time, got_s, exp_s));
    end else if (got_c !== exp_c) begin
      stop_with_error($sformatf("mismatch at %0t ns: flush_code is %0d, expected %0d",
                                $time, got_c, exp_c));
    end
  endtask

  task automatic check_occupancy(input logic [6:0] got_count, input logic [6:0] exp_count,
                                 input logic got_full, input logic exp_full);
    if (got_count !== exp_count) begin
      stop_with_error($sformatf("mismatch at %0t ns: count is %0d, expected %0d",
                                $time, got_count, exp_count));
    end else if (got_full !== exp_full) begin
      stop_with_error($sformatf("mismatch at %0t ns: full is %0d, expected %0d",
                                $time, got_full, exp_full));
    end
  endtask

  // Checks the outcome due at the next rising edge, then applies that edge to the model.
  task automatic observe();
    int front;
    int low_slot;
    bit complete;
    front = -1;
    low_slot = -1;
    complete = 1'b0;
    check_occupancy(count, 7'(order.size()), full, order.size() == rob_pkg::BUNDLES);
    check_bundle("alloc_bundle", alloc_bundle, bundle_idx_t'(model_tail));
    if (full) saw_full = 1'b1;
    if (order.size() > 0) begin
      front = order[0];
      complete = 1'b1;
      for (int s = 0; s < rob_pkg::SLOTS; s++) begin
        if (model_mem[front][s].used && !model_mem[front][s].done) complete = 1'b0;
        if (model_mem[front][s].used && model_mem[front][s].excp && low_slot < 0) low_slot = s;
      end
    end
    if ((retire || flush) && !complete) begin
      stop_with_error("A retire or flush came without a complete bundle at the head.");
    end else if (retire && low_slot >= 0) begin
      stop_with_error("A bundle holding an exception retired instead of flushing.");
    end else if (flush && low_slot < 0) begin
      stop_with_error("A flush came for a bundle without any exception.");
    end else if (stall >= 200) begin
      stop_with_error("The head bundle was complete but nothing left within 200 cycles.");
    end
    stall = (complete && !retire && !flush) ? stall + 1 : 0;
    if (retire) check_bundle("retire_bundle", retire_bundle, bundle_idx_t'(front));
    if (flush) begin
      check_flush(flush_bundle, bundle_idx_t'(front), flush_slot, slot_idx_t'(low_slot),
                  flush_code, model_mem[front][low_slot].code);
    end
    for (int p = 0; p < rob_pkg::NUM_WR; p++) begin
      if (wr[p].wen) model_mem[int'(wr[p].bundle)][int'(wr[p].slot)] = wr[p].entry;
    end
    if (flush) begin
      order.delete(); // A dispatch on the same edge is lost as well.
      model_tail = 0;
      flush_cnt++;
    end else begin
      if (retire) begin
        void'(order.pop_front());
        retire_cnt++;
      end
      if (dispatch) begin
        for (int s = 0; s < rob_pkg::SLOTS; s++) model_mem[model_tail][s] = dispatch_entries[s];
        order.push_back(model_tail);
        model_tail = (model_tail == rob_pkg::BUNDLES - 1) ? 0 : model_tail + 1;
      end
    end
  endtask

  task automatic step(input bit may_dispatch, input bit may_complete, input bit slot0_used);
    logic next_dispatch;
    rob_pkg::except_entry_t [rob_pkg::SLOTS-1:0] next_entries;
    rob_pkg::wr_req_t [rob_pkg::NUM_WR-1:0] next_wr;
    int b;
    int s;
    bit dup;
    bit empty;
    @(negedge clk);
    observe();
    next_dispatch = 1'b0;
    next_entries = '0;
    next_wr = '0;
    if (may_dispatch && order.size() < rob_pkg::BUNDLES && (slot0_used || rand_bits(1) == 1)) begin
      next_dispatch = 1'b1;
      empty = !slot0_used && (rand_bits(4) == 0); // Now and then a bundle with no used slot.
      for (int k = 0; k < rob_pkg::SLOTS; k++) begin
        next_entries[k].used = !empty && ((rand_bits(2) != 0) || (slot0_used && k == 0));
      end
    end
    for (int p = 0; p < rob_pkg::NUM_WR; p++) begin
      if (may_complete && order.size() > 0 && rand_bits(1) == 1) begin
        b = order[rand_bits(3) % order.size()]; // Mostly bundles near the head.
        s = rand_bits(4) % rob_pkg::SLOTS;
        dup = 1'b0;
        for (int q = 0; q < p; q++) begin
          if (next_wr[q].wen && next_wr[q].bundle == bundle_idx_t'(b) &&
              next_wr[q].slot == slot_idx_t'(s)) dup = 1'b1;
        end
        if (!dup && model_mem[b][s].used && !model_mem[b][s].done) begin
          next_wr[p].wen = 1'b1;
          next_wr[p].bundle = bundle_idx_t'(b);
          next_wr[p].slot = slot_idx_t'(s);
          next_wr[p].entry.used = 1'b1;
          next_wr[p].entry.done = 1'b1;
          next_wr[p].entry.excp = excp_en && (rand_bits(6) == 0);
          next_wr[p].entry.code = 4'(rand_bits(4));
        end
      end
    end
    @(posedge clk);
    dispatch <= next_dispatch;
    dispatch_entries <= next_entries;
    wr <= next_wr;
  endtask

  task automatic drain_buffer();
    int cycles;
    cycles = 0;
    while (order.size() > 0) begin
      if (cycles == 2000) begin
        stop_with_error("The buffer did not drain within 2000 cycles.");
      end else begin
        step(1'b0, 1'b1, 1'b0);
        cycles++;
      end
    end
  endtask

  initial begin
    int cycles;
    clk = 1'b0;
    rst_n = 1'b0;
    dispatch = 1'b0;
    dispatch_entries = '0;
    wr = '0;
    lfsr = 16'd11;
    model_tail = 0;
    stall = 0;
    retire_cnt = 0;
    flush_cnt = 0;
    saw_full = 1'b0;
    excp_en = 1'b1;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    repeat (5) step(1'b0, 1'b0, 1'b0);
    repeat (3000) step(1'b1, 1'b1, 1'b0);
    drain_buffer();
    cycles = 0;
    // Slot 0 stays pending so nothing can leave while the buffer fills up.
    while (order.size() < rob_pkg::BUNDLES) begin
      if (cycles == 200) begin
        stop_with_error("The buffer did not fill within 200 cycles.");
      end else begin
        step(1'b1, 1'b0, 1'b1);
        cycles++;
      end
    end
    repeat (3) step(1'b1, 1'b0, 1'b1);
    excp_en = 1'b0; // All 48 bundles now leave by retire, so head passes 47 to 0.
    drain_buffer();
    repeat (3) step(1'b0, 1'b0, 1'b0);
    if (saw_full && flush_cnt > 0 && retire_cnt > 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      stop_with_error("The run never saw a full buffer, a flush and a retire.");
    end
  end

endmodule

/* hdl/bundle_ptr.sv */
`timescale 1ns/1ns

module bundle_ptr #(
  parameter int DEPTH = 48
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         alloc,
  input  logic                         retire,
  input  logic                         flush,
  output logic [rob_pkg::BUNDLE_W-1:0] head,
  output logic [rob_pkg::BUNDLE_W-1:0] tail,
  output logic [6:0]                   count,
  output logic                         full
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head <= '0;
      tail <= '0;
      count <= '0;
    end else if (flush) begin
      head <= '0; // The whole buffer is dropped.
      tail <= '0;
      count <= '0;
    end else begin
      if (alloc) begin
        tail <= (tail == DEPTH - 1) ? '0 : tail + 1'b1;
      end
      if (retire) begin
        head <= (head == DEPTH - 1) ? '0 : head + 1'b1;
      end
      if (alloc && !retire) begin
        count <= count + 7'd1;
      end else if (retire && !alloc) begin
        count <= count - 7'd1;
      end
    end
  end

  assign full = (count == DEPTH);

  a_no_alloc_full: assert property (@(posedge clk) disable iff (!rst_n)
    alloc |-> !full);

  a_no_retire_empty: assert property (@(posedge clk) disable iff (!rst_n)
    retire |-> count != '0);

endmodule

/* hdl/except_bank.sv */
`timescale 1ns/1ns

module except_bank #(
  parameter int DEPTH = 48,
  parameter int N_WR = 4
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   read_step,
  input  logic [rob_pkg::BUNDLE_W-1:0]           read_bundle,
  output rob_pkg::except_entry_t                 read_entry,
  input  logic [N_WR-1:0][rob_pkg::BUNDLE_W-1:0] wr_bundle,
  input  rob_pkg::except_entry_t [N_WR-1:0]      wr_entry,
  input  logic [N_WR-1:0]                        wr_en,
  input  logic                                   init_en,
  input  logic [rob_pkg::BUNDLE_W-1:0]           init_bundle,
  input  rob_pkg::except_entry_t                 init_entry
);

  rob_pkg::except_entry_t mem [DEPTH];
  logic [rob_pkg::BUNDLE_W-1:0] read_idx;

  // Later assignments win, so port order sets the priority and init comes last.
  always_ff @(posedge clk) begin
    for (int i = 0; i < N_WR; i++) begin
      if (wr_en[i]) begin
        mem[wr_bundle[i]] <= wr_entry[i];
      end
    end
    if (init_en) begin
      mem[init_bundle] <= init_entry;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      read_idx <= '0;
    end else if (read_step) begin
      read_idx <= read_bundle; // Held until the next read step.
    end
  end

  assign read_entry = mem[read_idx];

  for (genvar i = 0; i < N_WR; i++) begin : g_idx_chk
    a_wr_idx: assert property (@(posedge clk) disable iff (!rst_n)
      wr_en[i] |-> wr_bundle[i] < DEPTH);
  end

  a_init_idx: assert property (@(posedge clk) disable iff (!rst_n)
    init_en |-> init_bundle < DEPTH);

endmodule

/* hdl/except_store.sv */
`timescale 1ns/1ns

module except_store #(
  parameter int DEPTH = 48,
  parameter int N_WR = 4,
  parameter int N_SLOTS = 10
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 read_step,
  input  logic [rob_pkg::BUNDLE_W-1:0]         read_bundle,
  output rob_pkg::except_entry_t [N_SLOTS-1:0] read_entries,
  input  rob_pkg::wr_req_t [N_WR-1:0]          wr,
  input  logic                                 init_en,
  input  logic [rob_pkg::BUNDLE_W-1:0]         init_bundle,
  input  rob_pkg::except_entry_t [N_SLOTS-1:0] init_entries
);

  logic [N_WR-1:0][rob_pkg::BUNDLE_W-1:0] wr_bundle;
  rob_pkg::except_entry_t [N_WR-1:0] wr_entry;

  // Index and payload are the same for every bank.
  always_comb begin
    for (int i = 0; i < N_WR; i++) begin
      wr_bundle[i] = wr[i].bundle;
      wr_entry[i] = wr[i].entry;
    end
  end

  for (genvar k = 0; k < N_SLOTS; k++) begin : g_bank
    logic [N_WR-1:0] bank_en;

    always_comb begin
      for (int i = 0; i < N_WR; i++) begin
        bank_en[i] = wr[i].wen && (int'(wr[i].slot) == k); // Slot field picks the bank.
      end
    end

    except_bank #(
      .DEPTH(DEPTH),
      .N_WR (N_WR)
    ) u_bank (
      .clk        (clk),
      .rst_n      (rst_n),
      .read_step  (read_step),
      .read_bundle(read_bundle),
      .read_entry (read_entries[k]),
      .wr_bundle  (wr_bundle),
      .wr_entry   (wr_entry),
      .wr_en      (bank_en),
      .init_en    (init_en),
      .init_bundle(init_bundle),
      .init_entry (init_entries[k])
    );
  end

  for (genvar i = 0; i < N_WR; i++) begin : g_slot_chk
    a_wr_slot: assert property (@(posedge clk) disable iff (!rst_n)
      wr[i].wen |-> wr[i].slot < N_SLOTS);
  end

endmodule

/* hdl/retire_ctrl.sv */
`timescale 1ns/1ns

module retire_ctrl #(
  parameter int N_SLOTS = 10
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [6:0]                           count,
  input  logic [rob_pkg::BUNDLE_W-1:0]         head,
  input  rob_pkg::except_entry_t [N_SLOTS-1:0] read_entries,
  output logic                                 read_step,
  output logic                                 retire,
  output logic [rob_pkg::BUNDLE_W-1:0]         retire_bundle,
  output logic                                 flush,
  output logic [rob_pkg::BUNDLE_W-1:0]         flush_bundle,
  output logic [rob_pkg::SLOT_W-1:0]           flush_slot,
  output logic [3:0]                           flush_code
);

  typedef enum logic {IDLE, EVAL} state_t;

  state_t state;
  logic all_done;
  logic any_excp;
  logic [rob_pkg::SLOT_W-1:0] excp_slot;
  logic [3:0] excp_code;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else if (state == IDLE) begin
      if (count != '0) begin
        state <= EVAL;
      end
    end else begin
      state <= IDLE; // Retire, flush or look again; all restart from IDLE.
    end
  end

  // Scan from the top down so the lowest excepting slot is the one left standing.
  always_comb begin
    all_done = 1'b1;
    any_excp = 1'b0;
    excp_slot = '0;
    excp_code = '0;
    for (int s = N_SLOTS - 1; s >= 0; s--) begin
      if (read_entries[s].used && !read_entries[s].done) begin
        all_done = 1'b0;
      end
      if (read_entries[s].used && read_entries[s].excp) begin
        any_excp = 1'b1;
        excp_slot = s[rob_pkg::SLOT_W-1:0];
        excp_code = read_entries[s].code;
      end
    end
  end

  assign read_step = (state == IDLE) && (count != '0);
  assign retire = (state == EVAL) && all_done && !any_excp;
  assign flush = (state == EVAL) && all_done && any_excp;

  // Head does not move between the read step and the evaluation.
  assign retire_bundle = head;
  assign flush_bundle = head;
  assign flush_slot = excp_slot;
  assign flush_code = excp_code;

  a_one_outcome: assert property (@(posedge clk) disable iff (!rst_n)
    !(retire && flush));

endmodule

/* hdl/rob_except_top.sv */
`timescale 1ns/1ns

module rob_except_top (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        dispatch,
  input  rob_pkg::except_entry_t [rob_pkg::SLOTS-1:0] dispatch_entries,
  input  rob_pkg::wr_req_t [rob_pkg::NUM_WR-1:0]      wr,
  output logic [rob_pkg::BUNDLE_W-1:0]                alloc_bundle,
  output logic                                        full,
  output logic [6:0]                                  count,
  output logic                                        retire,
  output logic [rob_pkg::BUNDLE_W-1:0]                retire_bundle,
  output logic                                        flush,
  output logic [rob_pkg::BUNDLE_W-1:0]                flush_bundle,
  output logic [rob_pkg::SLOT_W-1:0]                  flush_slot,
  output logic [3:0]                                  flush_code
);

  logic [rob_pkg::BUNDLE_W-1:0] head;
  logic read_step;
  rob_pkg::except_entry_t [rob_pkg::SLOTS-1:0] read_entries;

  except_store #(
    .DEPTH  (rob_pkg::BUNDLES),
    .N_WR   (rob_pkg::NUM_WR),
    .N_SLOTS(rob_pkg::SLOTS)
  ) u_store (
    .clk         (clk),
    .rst_n       (rst_n),
    .read_step   (read_step),
    .read_bundle (head),
    .read_entries(read_entries),
    .wr          (wr),
    .init_en     (dispatch),
    .init_bundle (alloc_bundle),
    .init_entries(dispatch_entries)
  );

  bundle_ptr #(
    .DEPTH(rob_pkg::BUNDLES)
  ) u_ptr (
    .clk   (clk),
    .rst_n (rst_n),
    .alloc (dispatch),
    .retire(retire),
    .flush (flush),
    .head  (head),
    .tail  (alloc_bundle),
    .count (count),
    .full  (full)
  );

  retire_ctrl #(
    .N_SLOTS(rob_pkg::SLOTS)
  ) u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .count        (count),
    .head         (head),
    .read_entries (read_entries),
    .read_step    (read_step),
    .retire       (retire),
    .retire_bundle(retire_bundle),
    .flush        (flush),
    .flush_bundle (flush_bundle),
    .flush_slot   (flush_slot),
    .flush_code   (flush_code)
  );

endmodule

/* hdl/rob_pkg.sv */
package rob_pkg;

  localparam int BUNDLES = 48;
  localparam int SLOTS = 10;
  localparam int BUNDLE_W = 6;
  localparam int SLOT_W = 4;
  localparam int NUM_WR = 4;

  // One slot's status. The code is only meaningful when excp is set.
  typedef struct packed {
    logic       used;
    logic       done;
    logic       excp;
    logic [3:0] code;
  } except_entry_t;

  // One completion from an execution port.
  typedef struct packed {
    logic                wen;
    logic [BUNDLE_W-1:0] bundle;
    logic [SLOT_W-1:0]   slot;
    except_entry_t       entry;
  } wr_req_t;

endpackage

/* list.f */
hdl/rob_pkg.sv
hdl/except_bank.sv
hdl/except_store.sv
hdl/bundle_ptr.sv
hdl/retire_ctrl.sv
hdl/rob_except_top.sv
dv/tb_rob_except.sv
